// File: bench/cpu16_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_checker (
	input logic clk,
	input cpu16_pkg::mem_req_t mem_req,
	input logic [15:0] output_port,
	input logic out_strobe,
	input logic [15:0] num_inst,
	input logic is_halted
);

	localparam int mem_words = 1 << cpu16_pkg::mem_aw;

	// program image, filled in by the testbench
	logic [15:0] img [mem_words];
	logic [15:0] wwd_q [$];
	logic [15:0] st_addr_q [$];
	logic [15:0] st_data_q [$];
	logic [15:0] exp_val;
	int exp_retired;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_no = 0;
	int cyc = 0;
	int post_halt = 0;
	bit active = 1'b0;
	bit test_done = 1'b0;
	bit halted_seen = 1'b0;

	// instruction-level model of the ISA
	task automatic run_model();
		logic [15:0] r [4];
		logic [15:0] m [mem_words];
		logic [15:0] ins;
		logic [15:0] pc;
		logic [15:0] cur;
		logic [15:0] simm;
		logic [15:0] ea;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		bit running;
		int steps;
		wwd_q.delete();
		st_addr_q.delete();
		st_data_q.delete();
		for (int i = 0; i < mem_words; i++)
			m[i] = img[i];
		for (int i = 0; i < 4; i++)
			r[i] = '0;
		pc = '0;
		running = 1'b1;
		steps = 0;
		exp_retired = 0;
		while (running && steps < 1000) begin
			cur = pc;
			ins = m[pc[cpu16_pkg::mem_aw-1:0]];
			rs = ins[11:10];
			rt = ins[9:8];
			rd = ins[7:6];
			simm = {{8{ins[7]}}, ins[7:0]};
			steps++;
			exp_retired++;
			pc = pc + 16'd1;
			case (ins[15:12])
				cpu16_pkg::op_rtype: begin
					case (ins[5:0])
						cpu16_pkg::fn_add: r[rd] = r[rs] + r[rt];
						cpu16_pkg::fn_sub: r[rd] = r[rs] - r[rt];
						cpu16_pkg::fn_and: r[rd] = r[rs] & r[rt];
						cpu16_pkg::fn_orr: r[rd] = r[rs] | r[rt];
						cpu16_pkg::fn_wwd: wwd_q.push_back(r[rs]);
						cpu16_pkg::fn_hlt: running = 1'b0;
						default: ;
					endcase
				end
				cpu16_pkg::op_adi: r[rt] = r[rs] + simm;
				cpu16_pkg::op_lhi: r[rt] = {ins[7:0], 8'h00};
				cpu16_pkg::op_lwd: begin
					ea = r[rs] + simm;
					r[rt] = m[ea[cpu16_pkg::mem_aw-1:0]];
				end
				cpu16_pkg::op_swd: begin
					ea = r[rs] + simm;
					m[ea[cpu16_pkg::mem_aw-1:0]] = r[rt];
					st_addr_q.push_back(ea);
					st_data_q.push_back(r[rt]);
				end
				cpu16_pkg::op_bne: if (r[rs] != r[rt]) pc = pc + simm;
				cpu16_pkg::op_beq: if (r[rs] == r[rt]) pc = pc + simm;
				cpu16_pkg::op_jmp: pc = {cur[15:12], ins[11:0]};
				default: ;
			endcase
		end
		if (running)
			report_msg("reference model did not reach HLT");
	endtask

	task automatic begin_test(input int n);
		test_no = n;
		test_errors = 0;
		cyc = 0;
		post_halt = 0;
		halted_seen = 1'b0;
		test_done = 1'b0;
		run_model();
		active = 1'b1;
	endtask

	task automatic report_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		$display("[FAIL] test %0d: %s = 0x%04h, expected 0x%04h", test_no, name, got, exp);
		errors++;
		test_errors++;
	endtask

	task automatic report_msg(input string what);
		$display("test %0d: error, %s", test_no, what);
		errors++;
		test_errors++;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("test %0d: pass, %0d instructions retired", test_no, exp_retired);
		end else begin
			$display("test %0d: fail, %0d errors", test_no, test_errors);
			tests_failed++;
		end
		tests_run++;
		active = 1'b0;
		test_done = 1'b1;
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (active) begin
			cyc++;
			if (cyc == 2) begin
				if (num_inst !== 16'h0)
					report_value("num_inst", num_inst, 16'h0);
				if (output_port !== 16'h0)
					report_value("output_port", output_port, 16'h0);
				if (is_halted !== 1'b0)
					report_value("is_halted", {15'h0, is_halted}, 16'h0);
				if (out_strobe !== 1'b0)
					report_value("out_strobe", {15'h0, out_strobe}, 16'h0);
				if (mem_req.write !== 1'b0)
					report_value("mem_req.write", {15'h0, mem_req.write}, 16'h0);
			end
			if (out_strobe) begin
				if (halted_seen) begin
					report_msg("WWD output after halt");
				end else if (wwd_q.size() == 0) begin
					report_msg("WWD output that the program never makes");
				end else begin
					exp_val = wwd_q.pop_front();
					if (output_port !== exp_val)
						report_value("output_port", output_port, exp_val);
				end
			end
			if (mem_req.read && mem_req.write)
				report_msg("read and write strobes high in the same cycle");
			if (mem_req.write) begin
				if (halted_seen) begin
					report_msg("memory write after halt");
				end else if (st_addr_q.size() == 0) begin
					report_msg("memory write that the program never makes");
				end else begin
					exp_val = st_addr_q.pop_front();
					if (mem_req.addr !== exp_val)
						report_value("mem_req.addr", mem_req.addr, exp_val);
					exp_val = st_data_q.pop_front();
					if (mem_req.wdata !== exp_val)
						report_value("mem_req.wdata", mem_req.wdata, exp_val);
				end
			end
			if (is_halted === 1'b1 && !halted_seen) begin
				halted_seen = 1'b1;
				if (num_inst !== exp_retired[15:0])
					report_value("num_inst", num_inst, exp_retired[15:0]);
				if (wwd_q.size() != 0)
					report_msg("expected WWD values still outstanding at halt");
				if (st_addr_q.size() != 0)
					report_msg("expected stores still outstanding at halt");
			end else if (halted_seen) begin
				if (is_halted !== 1'b1)
					report_msg("is_halted dropped after it rose");
				post_halt++;
				if (post_halt == 20)
					end_test();
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_cpu16.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu16;

	localparam int num_tests = 8;
	localparam int cycle_limit = num_tests * 64 * 5 + 500;
	localparam int mem_words = 1 << cpu16_pkg::mem_aw;

	logic clk;
	logic reset_n;
	logic [15:0] mem_rdata;
	cpu16_pkg::mem_req_t mem_req;
	logic [15:0] output_port;
	logic out_strobe;
	logic [15:0] num_inst;
	logic is_halted;
	logic [15:0] mem [mem_words];
	int cycles = 0;

	cpu16_top u_dut (
		.clk(clk),
		.reset_n(reset_n),
		.mem_rdata(mem_rdata),
		.mem_req(mem_req),
		.output_port(output_port),
		.out_strobe(out_strobe),
		.num_inst(num_inst),
		.is_halted(is_halted)
	);

	cpu16_checker u_chk (
		.clk(clk),
		.mem_req(mem_req),
		.output_port(output_port),
		.out_strobe(out_strobe),
		.num_inst(num_inst),
		.is_halted(is_halted)
	);

	// memory model reads while the read strobe is high and writes at the edge
	assign mem_rdata = mem_req.read ? mem[mem_req.addr[cpu16_pkg::mem_aw-1:0]] : 16'h0000;

	always @(posedge clk) begin
		if (mem_req.write)
			mem[mem_req.addr[cpu16_pkg::mem_aw-1:0]] <= mem_req.wdata;
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("run hung: no finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [15:0] enc_r(input logic [5:0] fn, input logic [1:0] rs,
			input logic [1:0] rt, input logic [1:0] rd);
		return {cpu16_pkg::op_rtype, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] enc_i(input logic [3:0] op, input logic [1:0] rs,
			input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// random program, r3 is kept as the data base register
	task automatic write_program();
		int len;
		int pos;
		int kind;
		int t;
		int br_pos [$];
		logic safe [64];
		logic [7:0] a;
		for (int i = 0; i < mem_words; i++) begin
			a = i[7:0];
			mem[i] = {a, ~a} ^ 16'h3c00;
		end
		for (int i = 0; i < 64; i++) begin
			mem[i] = 16'h0000;
			safe[i] = 1'b0;
		end
		len = 30 + $urandom % 27;
		pos = 0;
		while (pos < len) begin
			kind = $urandom % 10;
			safe[pos] = 1'b1;
			if (kind < 2 && pos + 3 <= len) begin
				mem[pos] = enc_i(cpu16_pkg::op_lhi, 2'd0, 2'd3, 8'h00);
				mem[pos + 1] = enc_i(cpu16_pkg::op_adi, 2'd3, 2'd3, 8'(64 + $urandom % 64));
				if ($urandom % 2)
					mem[pos + 2] = enc_i(cpu16_pkg::op_lwd, 2'd3, 2'($urandom % 3), 8'h00);
				else
					mem[pos + 2] = enc_i(cpu16_pkg::op_swd, 2'd3, 2'($urandom % 4), 8'h00);
				pos += 3;
			end else begin
				if (kind == 2)
					br_pos.push_back(pos);
				else if (kind == 3)
					mem[pos] = enc_r(cpu16_pkg::fn_wwd, 2'($urandom % 4), 2'd0, 2'd0);
				else if (kind == 4)
					mem[pos] = enc_i(cpu16_pkg::op_adi, 2'($urandom % 4),
							2'($urandom % 3), 8'($urandom));
				else if (kind == 5)
					mem[pos] = enc_i(cpu16_pkg::op_lhi, 2'd0, 2'($urandom % 3), 8'($urandom));
				else
					mem[pos] = enc_r(6'($urandom % 4), 2'($urandom % 4),
							2'($urandom % 4), 2'($urandom % 3));
				pos++;
			end
		end
		mem[len] = enc_r(cpu16_pkg::fn_wwd, 2'($urandom % 4), 2'd0, 2'd0);
		mem[len + 1] = enc_r(cpu16_pkg::fn_hlt, 2'd0, 2'd0, 2'd0);
		safe[len] = 1'b1;
		// forward targets never land inside a load or store group
		foreach (br_pos[k]) begin
			t = br_pos[k] + 1 + $urandom % (len - br_pos[k]);
			while (!safe[t])
				t++;
			kind = $urandom % 3;
			if (kind == 2)
				mem[br_pos[k]] = {cpu16_pkg::op_jmp, 12'(t)};
			else
				mem[br_pos[k]] = enc_i(kind == 0 ? cpu16_pkg::op_bne : cpu16_pkg::op_beq,
						2'($urandom % 4), 2'($urandom % 4), 8'(t - br_pos[k] - 1));
		end
		for (int i = 0; i < mem_words; i++)
			u_chk.img[i] = mem[i];
	endtask

	initial begin
		void'($urandom(63348));
		for (int n = 0; n < num_tests; n++) begin
			reset_n = 1'b0;
			write_program();
			repeat (5) @(posedge clk);
			#1;
			reset_n = 1'b1;
			u_chk.begin_test(n);
			while (!u_chk.test_done)
				@(posedge clk);
			#1;
		end
		$display("tests run %0d, failed %0d, errors %0d",
				u_chk.tests_run, u_chk.tests_failed, u_chk.errors);
		if (u_chk.errors == 0 && u_chk.tests_run == num_tests)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu16.f
rtl/cpu16_pkg.sv
rtl/alu_unit.sv
rtl/control_unit.sv
rtl/hazard_unit.sv
rtl/mem_arbiter.sv
rtl/pipeline_datapath.sv
rtl/cpu16_top.sv
bench/cpu16_checker.sv
bench/tb_cpu16.sv

// File: rtl/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
	input  logic [cpu16_pkg::word_w-1:0] a,
	input  logic [cpu16_pkg::word_w-1:0] b,
	input  cpu16_pkg::alu_op_t op,
	input  logic branch_eq,
	output logic [cpu16_pkg::word_w-1:0] result,
	output logic taken
);

	always_comb begin
		case (op)
			cpu16_pkg::alu_add: result = a + b;
			cpu16_pkg::alu_sub: result = a - b;
			cpu16_pkg::alu_and: result = a & b;
			cpu16_pkg::alu_or: result = a | b;
			cpu16_pkg::alu_pass_b: result = b;
			// low byte of b into the high byte
			cpu16_pkg::alu_lhi: result = {b[7:0], 8'h00};
			default: result = a + b;
		endcase
	end

	// BEQ on equality, BNE otherwise
	assign taken = branch_eq ? (a == b) : (a != b);

endmodule

`default_nettype wire

// File: rtl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  cpu16_pkg::instr_t instr,
	output cpu16_pkg::ctrl_t ctrl,
	output logic use_rs,
	output logic use_rt
);

	always_comb begin
		ctrl = '0;
		ctrl.rd_sel = cpu16_pkg::rd_sel_none;
		use_rs = 1'b0;
		use_rt = 1'b0;
		case (instr.rfields.opcode)
			cpu16_pkg::op_rtype: begin
				case (instr.rfields.func)
					cpu16_pkg::fn_add: ctrl.alu_op = cpu16_pkg::alu_add;
					cpu16_pkg::fn_sub: ctrl.alu_op = cpu16_pkg::alu_sub;
					cpu16_pkg::fn_and: ctrl.alu_op = cpu16_pkg::alu_and;
					cpu16_pkg::fn_orr: ctrl.alu_op = cpu16_pkg::alu_or;
					cpu16_pkg::fn_wwd: begin
						ctrl.wwd = 1'b1;
						use_rs = 1'b1;
					end
					cpu16_pkg::fn_hlt: ctrl.halt = 1'b1;
					default: ;
				endcase
				// arithmetic forms write rd from rs and rt
				if (instr.rfields.func <= cpu16_pkg::fn_orr) begin
					ctrl.reg_write = 1'b1;
					ctrl.rd_sel = cpu16_pkg::rd_sel_rd;
					use_rs = 1'b1;
					use_rt = 1'b1;
				end
			end
			cpu16_pkg::op_adi, cpu16_pkg::op_lwd: begin
				ctrl.alu_src = 1'b1;
				ctrl.mem_read = (instr.ifields.opcode == cpu16_pkg::op_lwd);
				ctrl.reg_write = 1'b1;
				ctrl.rd_sel = cpu16_pkg::rd_sel_rt;
				use_rs = 1'b1;
			end
			cpu16_pkg::op_lhi: begin
				ctrl.alu_op = cpu16_pkg::alu_lhi;
				ctrl.alu_src = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.rd_sel = cpu16_pkg::rd_sel_rt;
			end
			cpu16_pkg::op_swd: begin
				ctrl.alu_src = 1'b1;
				ctrl.mem_write = 1'b1;
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			cpu16_pkg::op_bne, cpu16_pkg::op_beq: begin
				ctrl.alu_op = cpu16_pkg::alu_sub;
				ctrl.branch = 1'b1;
				ctrl.branch_eq = (instr.ifields.opcode == cpu16_pkg::op_beq);
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			cpu16_pkg::op_jmp: begin
				ctrl.alu_op = cpu16_pkg::alu_pass_b;
				ctrl.jump = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/cpu16_pkg.sv
`default_nettype none

package cpu16_pkg;

	// data and address width
	localparam int word_w = 16;
	// address bits of the memory model
	localparam int mem_aw = 8;

	// opcodes
	localparam logic [3:0] op_bne = 4'd0;
	localparam logic [3:0] op_beq = 4'd1;
	localparam logic [3:0] op_adi = 4'd4;
	localparam logic [3:0] op_lhi = 4'd6;
	localparam logic [3:0] op_lwd = 4'd7;
	localparam logic [3:0] op_swd = 4'd8;
	localparam logic [3:0] op_jmp = 4'd9;
	localparam logic [3:0] op_rtype = 4'd15;

	// function codes of the R-type group
	localparam logic [5:0] fn_add = 6'd0;
	localparam logic [5:0] fn_sub = 6'd1;
	localparam logic [5:0] fn_and = 6'd2;
	localparam logic [5:0] fn_orr = 6'd3;
	localparam logic [5:0] fn_wwd = 6'd28;
	localparam logic [5:0] fn_hlt = 6'd29;

	// destination register choice
	localparam logic [1:0] rd_sel_none = 2'd0;
	localparam logic [1:0] rd_sel_rd = 2'd1;
	localparam logic [1:0] rd_sel_rt = 2'd2;

	// forwarding selects for the EX operands
	localparam logic [1:0] fwd_reg = 2'd0;
	localparam logic [1:0] fwd_mem = 2'd1;
	localparam logic [1:0] fwd_wb = 2'd2;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_pass_b,
		alu_lhi
	} alu_op_t;

	// one instruction word, read as R, I or J format
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [1:0] rd;
			logic [5:0] func;
		} rfields;
		struct packed {
			logic [3:0] opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [7:0] imm;
		} ifields;
		struct packed {
			logic [3:0] opcode;
			logic [11:0] target;
		} jfields;
	} instr_t;

	// all zero is a bubble
	typedef struct packed {
		alu_op_t alu_op;
		logic alu_src;
		logic branch;
		logic branch_eq;
		logic jump;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic [1:0] rd_sel;
		logic wwd;
		logic halt;
	} ctrl_t;

	typedef struct packed {
		logic read;
		logic write;
		logic [word_w-1:0] addr;
		logic [word_w-1:0] wdata;
	} mem_req_t;

endpackage

`default_nettype wire

// File: rtl/cpu16_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_top (
	input  logic clk,
	input  logic reset_n,
	input  logic [cpu16_pkg::word_w-1:0] mem_rdata,
	output cpu16_pkg::mem_req_t mem_req,
	output logic [cpu16_pkg::word_w-1:0] output_port,
	output logic out_strobe,
	output logic [cpu16_pkg::word_w-1:0] num_inst,
	output logic is_halted
);

	logic [cpu16_pkg::word_w-1:0] fetch_addr;
	logic fetch_en;
	logic fetch_grant;
	cpu16_pkg::mem_req_t data_req;
	cpu16_pkg::instr_t id_instr;
	cpu16_pkg::ctrl_t id_ctrl;
	logic use_rs;
	logic use_rt;
	logic [1:0] rs_id;
	logic [1:0] rt_id;
	logic use_rs_id;
	logic use_rt_id;
	logic [1:0] rs_ex;
	logic [1:0] rt_ex;
	logic [1:0] rd_ex;
	logic mem_read_ex;
	logic [1:0] rd_mem;
	logic reg_write_mem;
	logic [1:0] rd_wb;
	logic reg_write_wb;
	logic [1:0] fwd_a;
	logic [1:0] fwd_b;
	logic load_stall;
	logic [cpu16_pkg::word_w-1:0] alu_a;
	logic [cpu16_pkg::word_w-1:0] alu_b;
	cpu16_pkg::alu_op_t alu_op;
	logic branch_eq;
	logic [cpu16_pkg::word_w-1:0] alu_result;
	logic taken;

	// port names of the datapath match the nets here
	pipeline_datapath u_datapath (.*);

	control_unit u_control (
		.instr(id_instr),
		.ctrl(id_ctrl),
		.use_rs(use_rs),
		.use_rt(use_rt)
	);

	hazard_unit u_hazard (
		.rs_id(rs_id),
		.rt_id(rt_id),
		.use_rs(use_rs_id),
		.use_rt(use_rt_id),
		.rs_ex(rs_ex),
		.rt_ex(rt_ex),
		.rd_ex(rd_ex),
		.mem_read_ex(mem_read_ex),
		.rd_mem(rd_mem),
		.reg_write_mem(reg_write_mem),
		.rd_wb(rd_wb),
		.reg_write_wb(reg_write_wb),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.load_stall(load_stall)
	);

	alu_unit u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(alu_op),
		.branch_eq(branch_eq),
		.result(alu_result),
		.taken(taken)
	);

	mem_arbiter u_arbiter (
		.fetch_addr(fetch_addr),
		.fetch_en(fetch_en),
		.data_req(data_req),
		.mem_req(mem_req),
		.fetch_grant(fetch_grant)
	);

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  logic [1:0] rs_id,
	input  logic [1:0] rt_id,
	input  logic use_rs,
	input  logic use_rt,
	input  logic [1:0] rs_ex,
	input  logic [1:0] rt_ex,
	input  logic [1:0] rd_ex,
	input  logic mem_read_ex,
	input  logic [1:0] rd_mem,
	input  logic reg_write_mem,
	input  logic [1:0] rd_wb,
	input  logic reg_write_wb,
	output logic [1:0] fwd_a,
	output logic [1:0] fwd_b,
	output logic load_stall
);

	// newest writer wins
	function automatic logic [1:0] fwd_sel(input logic [1:0] src, input logic [1:0] mem_rd,
			input logic mem_we, input logic [1:0] wb_rd, input logic wb_we);
		if (mem_we && mem_rd == src)
			return cpu16_pkg::fwd_mem;
		else if (wb_we && wb_rd == src)
			return cpu16_pkg::fwd_wb;
		else
			return cpu16_pkg::fwd_reg;
	endfunction

	assign fwd_a = fwd_sel(rs_ex, rd_mem, reg_write_mem, rd_wb, reg_write_wb);
	assign fwd_b = fwd_sel(rt_ex, rd_mem, reg_write_mem, rd_wb, reg_write_wb);

	// load result is not ready for the very next instruction
	assign load_stall = mem_read_ex &
			((use_rs && rs_id == rd_ex) || (use_rt && rt_id == rd_ex));

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  logic [cpu16_pkg::word_w-1:0] fetch_addr,
	input  logic fetch_en,
	input  cpu16_pkg::mem_req_t data_req,
	output cpu16_pkg::mem_req_t mem_req,
	output logic fetch_grant
);

	logic data_active;

	// data access has the memory first
	assign data_active = data_req.read | data_req.write;
	assign fetch_grant = fetch_en & ~data_active;

	always_comb begin
		if (data_active) begin
			mem_req = data_req;
		end else begin
			mem_req.read = fetch_en;
			mem_req.write = 1'b0;
			mem_req.addr = fetch_addr;
			mem_req.wdata = '0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/pipeline_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_datapath (
	input  logic clk,
	input  logic reset_n,
	input  logic [cpu16_pkg::word_w-1:0] mem_rdata,
	input  logic fetch_grant,
	output logic [cpu16_pkg::word_w-1:0] fetch_addr,
	output logic fetch_en,
	output cpu16_pkg::mem_req_t data_req,
	output cpu16_pkg::instr_t id_instr,
	input  cpu16_pkg::ctrl_t id_ctrl,
	input  logic use_rs,
	input  logic use_rt,
	output logic [1:0] rs_id,
	output logic [1:0] rt_id,
	output logic use_rs_id,
	output logic use_rt_id,
	output logic [1:0] rs_ex,
	output logic [1:0] rt_ex,
	output logic [1:0] rd_ex,
	output logic mem_read_ex,
	output logic [1:0] rd_mem,
	output logic reg_write_mem,
	output logic [1:0] rd_wb,
	output logic reg_write_wb,
	input  logic [1:0] fwd_a,
	input  logic [1:0] fwd_b,
	input  logic load_stall,
	output logic [cpu16_pkg::word_w-1:0] alu_a,
	output logic [cpu16_pkg::word_w-1:0] alu_b,
	output cpu16_pkg::alu_op_t alu_op,
	output logic branch_eq,
	input  logic [cpu16_pkg::word_w-1:0] alu_result,
	input  logic taken,
	output logic [cpu16_pkg::word_w-1:0] output_port,
	output logic out_strobe,
	output logic [cpu16_pkg::word_w-1:0] num_inst,
	output logic is_halted
);

	localparam int w = cpu16_pkg::word_w;

	logic [w-1:0] pc;
	logic [w-1:0] pc_id;
	logic valid_id;
	logic [1:0] rd_id;
	logic [w-1:0] rs_val_id;
	logic [w-1:0] rt_val_id;
	cpu16_pkg::ctrl_t ctrl_id;
	cpu16_pkg::ctrl_t ex_ctrl;
	cpu16_pkg::ctrl_t mem_ctrl;
	cpu16_pkg::ctrl_t wb_ctrl;
	logic ex_valid;
	logic mem_valid;
	logic wb_valid;
	logic [w-1:0] ex_pc;
	logic [w-1:0] ex_rs_val;
	logic [w-1:0] ex_rt_val;
	logic [w-1:0] ex_imm;
	logic [11:0] ex_target;
	logic [w-1:0] mem_alu;
	logic [w-1:0] mem_store;
	logic [w-1:0] mem_rs_val;
	logic [w-1:0] wb_alu;
	logic [w-1:0] wb_load;
	logic [w-1:0] wb_rs_val;
	logic [w-1:0] wb_data;
	logic [w-1:0] regs [4];
	logic [w-1:0] a_fwd;
	logic [w-1:0] b_fwd;
	logic [w-1:0] next_pc;
	logic redirect;
	logic flush;
	logic front_hold;
	logic halt_pending;

	function automatic logic [w-1:0] pick(input logic [1:0] sel, input logic [w-1:0] reg_val,
			input logic [w-1:0] mem_val, input logic [w-1:0] wb_val);
		case (sel)
			cpu16_pkg::fwd_mem: return mem_val;
			cpu16_pkg::fwd_wb: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// ID stage, bubbles decode to nothing
	assign ctrl_id = valid_id ? id_ctrl : '0;
	assign use_rs_id = valid_id & use_rs;
	assign use_rt_id = valid_id & use_rt;
	assign rs_id = id_instr.rfields.rs;
	assign rt_id = id_instr.rfields.rt;

	always_comb begin
		case (ctrl_id.rd_sel)
			cpu16_pkg::rd_sel_rd: rd_id = id_instr.rfields.rd;
			cpu16_pkg::rd_sel_rt: rd_id = id_instr.rfields.rt;
			default: rd_id = 2'd0;
		endcase
	end

	// register file reads see the write of the same cycle
	assign rs_val_id = (reg_write_wb && rd_wb == rs_id) ? wb_data : regs[rs_id];
	assign rt_val_id = (reg_write_wb && rd_wb == rt_id) ? wb_data : regs[rt_id];

	// fetch stops from a decoded HLT onward
	assign halt_pending = ctrl_id.halt | ex_ctrl.halt | mem_ctrl.halt | wb_ctrl.halt | is_halted;
	assign fetch_en = ~halt_pending;
	assign fetch_addr = pc;
	assign front_hold = load_stall | (fetch_en & ~fetch_grant);

	// EX stage
	assign a_fwd = pick(fwd_a, ex_rs_val, mem_alu, wb_data);
	assign b_fwd = pick(fwd_b, ex_rt_val, mem_alu, wb_data);
	assign alu_a = a_fwd;
	assign alu_b = ex_ctrl.alu_src ? ex_imm : b_fwd;
	assign alu_op = ex_ctrl.alu_op;
	assign branch_eq = ex_ctrl.branch_eq;

	assign redirect = ex_ctrl.jump | (ex_ctrl.branch & taken);
	always_comb begin
		if (ex_ctrl.jump)
			next_pc = {ex_pc[w-1 -: 4], ex_target};
		else if (ex_ctrl.branch && taken)
			next_pc = ex_pc + 1'b1 + ex_imm;
		else
			next_pc = ex_pc + 1'b1;
	end

	// the ID slot holds the sequential successor of the branch
	assign flush = redirect & (next_pc != pc_id);

	// MEM and WB stages
	assign mem_read_ex = ex_ctrl.mem_read;
	assign reg_write_mem = mem_ctrl.reg_write;
	assign reg_write_wb = wb_ctrl.reg_write;
	assign data_req.read = mem_ctrl.mem_read;
	assign data_req.write = mem_ctrl.mem_write;
	assign data_req.addr = mem_alu;
	assign data_req.wdata = mem_store;
	assign wb_data = wb_ctrl.mem_read ? wb_load : wb_alu;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			valid_id <= 1'b0;
			ex_ctrl <= '0;
			ex_valid <= 1'b0;
			mem_ctrl <= '0;
			mem_valid <= 1'b0;
			wb_ctrl <= '0;
			wb_valid <= 1'b0;
			output_port <= '0;
			out_strobe <= 1'b0;
			num_inst <= '0;
			is_halted <= 1'b0;
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else begin
			if (flush)
				pc <= next_pc;
			else if (fetch_grant && !load_stall)
				pc <= pc + 1'b1;

			if (flush)
				valid_id <= 1'b0;
			else if (!front_hold)
				valid_id <= fetch_grant;

			// squashed or held ID leaves a bubble in EX
			if (flush || front_hold) begin
				ex_ctrl <= '0;
				ex_valid <= 1'b0;
			end else begin
				ex_ctrl <= ctrl_id;
				ex_valid <= valid_id;
			end

			mem_ctrl <= ex_ctrl;
			mem_valid <= ex_valid;
			wb_ctrl <= mem_ctrl;
			wb_valid <= mem_valid;

			if (reg_write_wb)
				regs[rd_wb] <= wb_data;
			out_strobe <= wb_ctrl.wwd;
			if (wb_ctrl.wwd)
				output_port <= wb_rs_val;
			if (wb_valid)
				num_inst <= num_inst + 1'b1;
			if (wb_valid && wb_ctrl.halt)
				is_halted <= 1'b1;
		end
	end

	// payload follows the control bits
	always_ff @(posedge clk) begin
		if (fetch_grant && !front_hold) begin
			id_instr <= mem_rdata;
			pc_id <= pc;
		end
		ex_pc <= pc_id;
		ex_rs_val <= rs_val_id;
		ex_rt_val <= rt_val_id;
		ex_imm <= {{(w - 8){id_instr.ifields.imm[7]}}, id_instr.ifields.imm};
		ex_target <= id_instr.jfields.target;
		rs_ex <= rs_id;
		rt_ex <= rt_id;
		rd_ex <= rd_id;
		mem_alu <= alu_result;
		mem_store <= b_fwd;
		mem_rs_val <= a_fwd;
		rd_mem <= rd_ex;
		wb_alu <= mem_alu;
		wb_load <= mem_rdata;
		wb_rs_val <= mem_rs_val;
		rd_wb <= rd_mem;
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_cpu16 -f cpu16.f -o sim_cpu16 &&
./obj_dir/sim_cpu16 | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
